//--- logic/isaPkg.sv
package isaPkg;

    typedef logic [15:0] opcodeT; // Instruction word
    typedef logic [3:0] flagsT;
    typedef logic [2:0] regSelT; // Source or destination field
    typedef logic [3:0] aluFuncT;

    typedef enum logic [3:0] {
        CLASS_A,
        CLASS_I,
        CLASS_J,
        CLASS_SI,
        CLASS_F_TAKEN, // Condition holds
        CLASS_F_SKIP,
        CLASS_PUSH,
        CLASS_POP,
        CLASS_INVALID
    } instrClassT;

    // Destination field codes
    localparam regSelT DEST_0 = 3'd0; // SP for I class, flags for POP
    localparam regSelT DEST_A = 3'd1;
    localparam regSelT DEST_B = 3'd2;
    localparam regSelT DEST_C = 3'd3;
    localparam regSelT DEST_ADR = 3'd4; // Memory at address in A
    localparam regSelT DEST_ABS = 3'd5;
    localparam regSelT DEST_STACK = 3'd6; // FP relative

    // Source modes with bit 2 set read memory
    localparam regSelT SRC_IMMED = 3'd4;
    localparam regSelT SRC_ABS = 3'd5;
    localparam regSelT SRC_ADDR = 3'd6;
    localparam regSelT SRC_STACK = 3'd7;

    localparam aluFuncT ALU_ADD = 4'd0;
    localparam aluFuncT ALU_SUB = 4'd2;

endpackage

//--- logic/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [5:0] {
        START = 6'd0,
        FETCH = 6'd1,
        ATYPE = 6'd2,
        ITYPE = 6'd3,
        JTYPE = 6'd4,
        SITYPE = 6'd5,
        FTYPE = 6'd6,
        PUSH1 = 6'd8,
        PUSH2 = 6'd9,
        POP1 = 6'd10,
        POP2 = 6'd11,
        RIMMED = 6'd20, // Operand read states
        RADDRESS = 6'd21,
        RABSOLUTE1_1 = 6'd22,
        RABSOLUTE1_2 = 6'd23,
        RABSOLUTE2 = 6'd24,
        RSTACK1 = 6'd25,
        RSTACK2 = 6'd26,
        WABSOLUTE1_1 = 6'd27, // Write-back states
        WABSOLUTE1_2 = 6'd28,
        WSTACK1 = 6'd29,
        WSTACK2 = 6'd30,
        WABSOLUTE2 = 6'd31,
        HALT = 6'b111111 // Invalid instruction
    } ctrlStateT;

    typedef logic [2:0] memAddrSelT; // Memory address source
    localparam memAddrSelT READ_FROM_PC = 3'd0;
    localparam memAddrSelT READ_FROM_A = 3'd1;
    localparam memAddrSelT READ_FROM_SP = 3'd2;
    localparam memAddrSelT READ_FROM_ALU = 3'd3;

    // Codes 0 to 3 of both ALU selects pick a register
    typedef logic [3:0] aluASelT;
    localparam aluASelT ALU1_FROM_PC = 4'd4;
    localparam aluASelT ALU1_FROM_SP = 4'd5;
    localparam aluASelT ALU1_FROM_MEM = 4'd6;
    localparam aluASelT ALU1_FROM_HIMEM = 4'd7; // High operand latch

    typedef logic [3:0] aluBSelT;
    localparam aluBSelT ALU2_FROM_1 = 4'd4;
    localparam aluBSelT ALU2_FROM_0 = 4'd5;
    localparam aluBSelT ALU2_FROM_OP = 4'd6; // Immediate field of opcode
    localparam aluBSelT ALU2_FROM_ADDR = 4'd7;
    localparam aluBSelT ALU2_FROM_FP = 4'd8;

    typedef logic [3:0] writeSrcT; // Memory write data source
    localparam writeSrcT WRITE_FROM_ALU = 4'd0;
    localparam writeSrcT WRITE_FROM_RES = 4'd1; // Saved result register

    localparam logic FLAG_FROM_ALU_OUT = 1'b1;

endpackage

//--- logic/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;

    isaPkg::instrClassT instrClass;
    isaPkg::regSelT srcSel;
    isaPkg::regSelT destSel; // Already picked from the class field
    isaPkg::aluFuncT aluOp;
    logic needsOperand; // Memory operand read before the main state

    modport decoder (output instrClass, srcSel, destSel, aluOp, needsOperand);
    modport seq (input instrClass, srcSel, destSel, needsOperand);
    modport dp (input srcSel, destSel, aluOp);
    modport mem (input destSel);

endinterface

//--- logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input isaPkg::opcodeT opcode,
    input isaPkg::flagsT flags,
    decodeIf.decoder dec
);

    isaPkg::regSelT srcField;
    logic shiftNoOperand; // I-class form whose source is not read from memory
    logic operandClass;

    assign srcField = opcode[11:9];
    assign dec.srcSel = srcField;

    always_comb begin
        dec.instrClass = isaPkg::CLASS_INVALID;
        if (opcode[15:12] == 4'b0000) begin
            dec.instrClass = isaPkg::CLASS_A;
        end else if (opcode[15:14] == 2'b01) begin
            dec.instrClass = isaPkg::CLASS_I;
        end else if (opcode[15]) begin
            dec.instrClass = isaPkg::CLASS_J;
        end else if (opcode[15:12] == 4'b0001) begin
            dec.instrClass = isaPkg::CLASS_SI;
        end else if (opcode[15:12] == 4'b0010 && !opcode[8]) begin
            if (flags[opcode[10:9]] == opcode[11]) begin // Selected flag vs wanted value
                dec.instrClass = isaPkg::CLASS_F_TAKEN;
            end else begin
                dec.instrClass = isaPkg::CLASS_F_SKIP;
            end
        end else if (opcode[15:12] == 4'b0011) begin
            if (opcode[8:7] == 2'b00) begin
                dec.instrClass = isaPkg::CLASS_PUSH;
            end else if (opcode[8:7] == 2'b01) begin
                dec.instrClass = isaPkg::CLASS_POP;
            end
        end
    end

    always_comb begin
        dec.destSel = srcField;
        dec.aluOp = isaPkg::ALU_ADD;
        case (dec.instrClass)
            isaPkg::CLASS_A: begin
                dec.destSel = opcode[2:0];
                dec.aluOp = opcode[8:5];
            end
            isaPkg::CLASS_I: begin
                dec.aluOp = {opcode[8], opcode[8], opcode[13:12]};
            end
            isaPkg::CLASS_SI: begin
                dec.destSel = opcode[6:4];
                dec.aluOp = {2'b10, opcode[8:7]}; // Shift group
            end
            default: begin
            end
        endcase
    end

    assign shiftNoOperand = dec.instrClass == isaPkg::CLASS_I && opcode[8]
                            && opcode[13:12] == 2'b11;
    assign operandClass = dec.instrClass inside {isaPkg::CLASS_A, isaPkg::CLASS_I,
                                                 isaPkg::CLASS_SI, isaPkg::CLASS_PUSH};
    assign dec.needsOperand = operandClass && srcField[2] && !shiftNoOperand;

endmodule

//--- logic/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input logic clk,
    input logic rst,
    input logic stall,
    decodeIf.seq dec,
    output ctrlPkg::ctrlStateT state
);

    ctrlPkg::ctrlStateT nextState;
    ctrlPkg::ctrlStateT mainState; // Main state of the decoded class
    ctrlPkg::ctrlStateT writeState; // Exit of a main state by destination

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrlPkg::START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    always_comb begin
        case (dec.instrClass)
            isaPkg::CLASS_A: mainState = ctrlPkg::ATYPE;
            isaPkg::CLASS_I: mainState = ctrlPkg::ITYPE;
            isaPkg::CLASS_J: mainState = ctrlPkg::JTYPE;
            isaPkg::CLASS_SI: mainState = ctrlPkg::SITYPE;
            isaPkg::CLASS_F_TAKEN: mainState = ctrlPkg::FTYPE;
            isaPkg::CLASS_F_SKIP: mainState = ctrlPkg::FETCH; // Branch not taken
            isaPkg::CLASS_PUSH: mainState = ctrlPkg::PUSH1;
            isaPkg::CLASS_POP: mainState = ctrlPkg::POP1;
            default: mainState = ctrlPkg::HALT;
        endcase
    end

    always_comb begin
        case (dec.destSel)
            isaPkg::DEST_ABS: writeState = ctrlPkg::WABSOLUTE1_1;
            isaPkg::DEST_STACK: writeState = ctrlPkg::WSTACK1;
            default: writeState = ctrlPkg::FETCH;
        endcase
    end

    always_comb begin
        nextState = ctrlPkg::HALT;
        case (state)
            ctrlPkg::START: nextState = ctrlPkg::FETCH;
            ctrlPkg::FETCH: begin
                if (!dec.needsOperand) begin
                    nextState = mainState;
                end else begin
                    case (dec.srcSel) // Operand read detour
                        isaPkg::SRC_IMMED: nextState = ctrlPkg::RIMMED;
                        isaPkg::SRC_ADDR: nextState = ctrlPkg::RADDRESS;
                        isaPkg::SRC_ABS: nextState = ctrlPkg::RABSOLUTE1_1;
                        isaPkg::SRC_STACK: nextState = ctrlPkg::RSTACK1;
                        default: nextState = ctrlPkg::HALT;
                    endcase
                end
            end
            ctrlPkg::RIMMED, ctrlPkg::RADDRESS, ctrlPkg::RABSOLUTE2, ctrlPkg::RSTACK2:
                nextState = mainState;
            ctrlPkg::RABSOLUTE1_1: nextState = ctrlPkg::RABSOLUTE1_2;
            ctrlPkg::RABSOLUTE1_2: nextState = ctrlPkg::RABSOLUTE2;
            ctrlPkg::RSTACK1: nextState = ctrlPkg::RSTACK2;
            ctrlPkg::ATYPE, ctrlPkg::ITYPE, ctrlPkg::SITYPE, ctrlPkg::POP2:
                nextState = writeState;
            ctrlPkg::WABSOLUTE1_1: nextState = ctrlPkg::WABSOLUTE1_2;
            ctrlPkg::WABSOLUTE1_2: nextState = ctrlPkg::WABSOLUTE2;
            ctrlPkg::WSTACK1: nextState = ctrlPkg::WSTACK2;
            ctrlPkg::PUSH1: nextState = ctrlPkg::PUSH2;
            ctrlPkg::POP1: nextState = ctrlPkg::POP2;
            ctrlPkg::JTYPE, ctrlPkg::FTYPE, ctrlPkg::PUSH2,
            ctrlPkg::WABSOLUTE2, ctrlPkg::WSTACK2: nextState = ctrlPkg::FETCH;
            default: nextState = ctrlPkg::HALT;
        endcase
    end

    // Stall freezes the whole sequence, not just the next step
    stallHold: assert property (@(posedge clk) !rst && stall |=> $stable(state))
        else $error("state changed while stalled");

    haltSticky: assert property (@(posedge clk)
        !rst && state == ctrlPkg::HALT |=> state == ctrlPkg::HALT)
        else $error("left HALT without reset");

endmodule

//--- logic/datapathControl.sv
`timescale 1ns/1ps

module datapathControl (
    input ctrlPkg::ctrlStateT state,
    decodeIf.dp dec,
    input isaPkg::opcodeT opcode,
    output ctrlPkg::aluASelT aluA,
    output ctrlPkg::aluBSelT aluB,
    output isaPkg::aluFuncT aluFunc,
    output logic enPC,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic enF,
    output logic enSP,
    output logic enFP,
    output logic sourceF,
    output logic initSPFP
);

    localparam isaPkg::aluFuncT JumpFunc = 4'b0110; // PC plus signed target

    ctrlPkg::aluASelT srcOperand; // Register or latched memory operand
    logic writesDest;

    assign srcOperand = dec.srcSel[2] ? ctrlPkg::ALU1_FROM_MEM
                                      : ctrlPkg::aluASelT'({2'b00, dec.srcSel[1:0]});
    assign writesDest = state inside {ctrlPkg::ATYPE, ctrlPkg::ITYPE,
                                      ctrlPkg::SITYPE, ctrlPkg::POP2};

    always_comb begin
        aluA = '0;
        aluB = '0;
        aluFunc = isaPkg::ALU_ADD;
        enPC = 1'b0;
        enA = 1'b0;
        enB = 1'b0;
        enC = 1'b0;
        enF = 1'b0;
        enSP = 1'b0;
        enFP = 1'b0;
        sourceF = 1'b0;
        initSPFP = 1'b0;
        case (state)
            ctrlPkg::START: begin
                initSPFP = 1'b1;
                enSP = 1'b1;
                enFP = 1'b1;
            end
            ctrlPkg::FETCH, ctrlPkg::RIMMED, ctrlPkg::RABSOLUTE1_1, ctrlPkg::RABSOLUTE1_2,
            ctrlPkg::RSTACK1, ctrlPkg::WABSOLUTE1_1, ctrlPkg::WABSOLUTE1_2,
            ctrlPkg::WSTACK1: begin
                aluA = ctrlPkg::ALU1_FROM_PC; // Step past the word just read
                aluB = ctrlPkg::ALU2_FROM_1;
                enPC = 1'b1;
            end
            ctrlPkg::ATYPE: begin
                aluA = srcOperand;
                aluB = {2'b00, opcode[4:3]};
                aluFunc = dec.aluOp;
                enF = |opcode; // NOP keeps flags
            end
            ctrlPkg::ITYPE: begin
                aluA = (dec.srcSel == 3'b000) ? ctrlPkg::ALU1_FROM_SP : srcOperand;
                aluB = ctrlPkg::ALU2_FROM_OP;
                aluFunc = dec.aluOp;
                enF = 1'b1;
            end
            ctrlPkg::SITYPE: begin
                aluA = srcOperand;
                aluB = ctrlPkg::ALU2_FROM_OP; // Shift amount
                aluFunc = dec.aluOp;
                enF = 1'b1;
            end
            ctrlPkg::JTYPE: begin
                aluA = ctrlPkg::ALU1_FROM_PC;
                aluB = ctrlPkg::ALU2_FROM_ADDR;
                aluFunc = JumpFunc;
                enPC = 1'b1;
            end
            ctrlPkg::FTYPE: begin
                aluA = ctrlPkg::ALU1_FROM_PC; // Relative branch
                aluB = ctrlPkg::ALU2_FROM_OP;
                enPC = 1'b1;
            end
            ctrlPkg::PUSH1: begin
                aluA = srcOperand; // Pass value through to memory
                aluB = ctrlPkg::ALU2_FROM_0;
            end
            ctrlPkg::PUSH2: begin
                aluA = ctrlPkg::ALU1_FROM_SP;
                aluB = ctrlPkg::ALU2_FROM_1;
                aluFunc = isaPkg::ALU_SUB;
                enSP = 1'b1;
            end
            ctrlPkg::POP1: begin
                aluA = ctrlPkg::ALU1_FROM_SP; // SP plus 1 also addresses the read
                aluB = ctrlPkg::ALU2_FROM_1;
                enSP = 1'b1;
            end
            ctrlPkg::POP2: begin
                aluA = ctrlPkg::ALU1_FROM_MEM;
                aluB = ctrlPkg::ALU2_FROM_0;
            end
            ctrlPkg::RABSOLUTE2, ctrlPkg::WABSOLUTE2: begin
                aluA = ctrlPkg::ALU1_FROM_HIMEM;
                aluB = ctrlPkg::ALU2_FROM_0;
            end
            ctrlPkg::RSTACK2, ctrlPkg::WSTACK2: begin
                aluA = ctrlPkg::ALU1_FROM_MEM; // Offset plus FP
                aluB = ctrlPkg::ALU2_FROM_FP;
            end
            default: begin
            end
        endcase
        if (writesDest) begin
            case (dec.destSel)
                isaPkg::DEST_0: begin
                    if (state == ctrlPkg::ITYPE) begin
                        enSP = 1'b1;
                    end else if (state == ctrlPkg::POP2) begin
                        enF = 1'b1; // POP into flags
                        sourceF = ctrlPkg::FLAG_FROM_ALU_OUT;
                    end
                end
                isaPkg::DEST_A: enA = 1'b1;
                isaPkg::DEST_B: enB = 1'b1;
                isaPkg::DEST_C: enC = 1'b1;
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        regEnOneHot: assert final ($onehot0({enA, enB, enC}))
            else $error("several register enables at once");
    end

endmodule

//--- logic/memoryControl.sv
`timescale 1ns/1ps

module memoryControl (
    input ctrlPkg::ctrlStateT state,
    decodeIf.mem dec,
    output ctrlPkg::memAddrSelT memAddr,
    output ctrlPkg::writeSrcT writeDataSource,
    output logic re,
    output logic we,
    output logic readStack,
    output logic saveOpcode,
    output logic saveMem1,
    output logic saveMem2,
    output logic saveResult
);

    logic writesDest;

    assign writesDest = state inside {ctrlPkg::ATYPE, ctrlPkg::ITYPE,
                                      ctrlPkg::SITYPE, ctrlPkg::POP2};

    always_comb begin
        memAddr = ctrlPkg::READ_FROM_PC;
        writeDataSource = ctrlPkg::WRITE_FROM_ALU;
        re = 1'b0;
        we = 1'b0;
        readStack = 1'b0;
        saveOpcode = 1'b0;
        saveMem1 = 1'b0;
        saveMem2 = 1'b0;
        saveResult = 1'b0;
        case (state)
            ctrlPkg::FETCH: begin
                re = 1'b1;
                saveOpcode = 1'b1;
            end
            ctrlPkg::RIMMED, ctrlPkg::RABSOLUTE1_2, ctrlPkg::RSTACK1,
            ctrlPkg::WABSOLUTE1_2, ctrlPkg::WSTACK1: begin
                re = 1'b1; // Word at PC
                saveMem1 = 1'b1;
            end
            ctrlPkg::RABSOLUTE1_1, ctrlPkg::WABSOLUTE1_1: begin
                re = 1'b1; // High address word
                saveMem2 = 1'b1;
            end
            ctrlPkg::RADDRESS: begin
                memAddr = ctrlPkg::READ_FROM_A;
                re = 1'b1;
                saveMem1 = 1'b1;
            end
            ctrlPkg::RABSOLUTE2, ctrlPkg::RSTACK2, ctrlPkg::POP1: begin
                memAddr = ctrlPkg::READ_FROM_ALU;
                re = 1'b1;
                readStack = state != ctrlPkg::RABSOLUTE2;
                saveMem1 = 1'b1;
            end
            ctrlPkg::WABSOLUTE2, ctrlPkg::WSTACK2: begin
                memAddr = ctrlPkg::READ_FROM_ALU;
                we = 1'b1;
                readStack = state == ctrlPkg::WSTACK2;
                writeDataSource = ctrlPkg::WRITE_FROM_RES;
            end
            ctrlPkg::PUSH1: begin
                memAddr = ctrlPkg::READ_FROM_SP;
                we = 1'b1;
                readStack = 1'b1;
            end
            default: begin
            end
        endcase
        if (writesDest) begin
            case (dec.destSel)
                isaPkg::DEST_ADR: begin
                    memAddr = ctrlPkg::READ_FROM_A;
                    we = 1'b1;
                end
                isaPkg::DEST_ABS, isaPkg::DEST_STACK: begin
                    saveResult = 1'b1; // Held for the write-back states
                    saveMem1 = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        noReadWrite: assert final (!(re && we))
            else $error("read and write strobes together");
    end

endmodule

//--- logic/cpuController.sv
`timescale 1ns/1ps

module cpuController (
    input logic clk,
    input logic rst,
    input logic [15:0] opcode, // Current instruction
    input logic [3:0] flags,
    input logic stall,
    output logic [2:0] memAddr,
    output logic [3:0] writeDataSource,
    output logic re,
    output logic we,
    output logic readStack,
    output logic saveOpcode,
    output logic saveMem1,
    output logic saveMem2,
    output logic saveResult,
    output logic [3:0] aluA,
    output logic [3:0] aluB,
    output logic [3:0] aluFunc,
    output logic enPC,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic enF,
    output logic enSP,
    output logic enFP,
    output logic sourceF,
    output logic initSPFP,
    output logic [5:0] state // Debug view of the FSM
);

    decodeIf dec ();
    ctrlPkg::ctrlStateT curState;

    assign state = curState;

    instrDecoder decoder_i (
        .opcode(opcode),
        .flags(flags),
        .dec(dec.decoder)
    );

    controlSequencer sequencer_i (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .dec(dec.seq),
        .state(curState)
    );

    datapathControl datapath_i (
        .state(curState),
        .dec(dec.dp),
        .opcode(opcode),
        .aluA(aluA),
        .aluB(aluB),
        .aluFunc(aluFunc),
        .enPC(enPC),
        .enA(enA),
        .enB(enB),
        .enC(enC),
        .enF(enF),
        .enSP(enSP),
        .enFP(enFP),
        .sourceF(sourceF),
        .initSPFP(initSPFP)
    );

    memoryControl memory_i (
        .state(curState),
        .dec(dec.mem),
        .memAddr(memAddr),
        .writeDataSource(writeDataSource),
        .re(re),
        .we(we),
        .readStack(readStack),
        .saveOpcode(saveOpcode),
        .saveMem1(saveMem1),
        .saveMem2(saveMem2),
        .saveResult(saveResult)
    );

endmodule

//--- sim/cpuControllerTb.sv
`timescale 1ns/1ps

module cpuControllerTb;

    localparam int NumCases = 24;
    localparam int RecWords = 16; // Words per line of the cases file
    localparam int MaxCycles = 20 * NumCases + 10;

    logic clk = 1'b0;
    logic rst;
    logic [15:0] opcode;
    logic [3:0] flags;
    logic stall;
    logic [2:0] memAddr;
    logic [3:0] writeDataSource, aluA, aluB, aluFunc;
    logic re, we, readStack, saveOpcode, saveMem1, saveMem2, saveResult;
    logic enPC, enA, enB, enC, enF, enSP, enFP, sourceF, initSPFP;
    logic [5:0] state;
    logic [40:0] allOuts; // Every DUT output, for the stall hold check
    logic [40:0] snapshot;

    logic [15:0] caseMem [0:NumCases*RecWords-1];
    logic [31:0] rng = 32'ha577_6519;
    int errors = 0;
    int failedTests = 0;
    int cycles = 0;
    int base, idx, len, mainIdx, stallLeft, stallAt, errBefore;

    cpuController dut_i (.*);

    assign allOuts = {memAddr, writeDataSource, re, we, readStack, saveOpcode, saveMem1,
                      saveMem2, saveResult, aluA, aluB, aluFunc, enPC, enA, enB, enC, enF,
                      enSP, enFP, sourceF, initSPFP, state};

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("timeout after %0d cycles, the FSM never finished its cases", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223; // LCG step
    endfunction

    function automatic logic [3:0] expectedAluFunc(input logic [15:0] op);
        if (op[15:14] == 2'b01) begin
            return {op[8], op[8], op[13:12]}; // I class
        end else if (op[15:12] == 4'b0001) begin
            return {2'b10, op[8:7]}; // SI shift group
        end
        return op[8:5];
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // State plus the strobes that this state must show
    task automatic verifyStep(input logic [5:0] expState, input logic [15:0] op,
                              input logic isMain, input logic [5:0] expSummary);
        checkValue("state", state, expState);
        if (isMain) begin
            checkValue("{enA,enB,enC,we,saveResult,enF}",
                       {enA, enB, enC, we, saveResult, enF}, expSummary);
        end
        case (expState)
            ctrlPkg::FETCH: begin
                checkValue("{re,saveOpcode,enPC}", {re, saveOpcode, enPC}, 3'b111);
                checkValue("memAddr", memAddr, ctrlPkg::READ_FROM_PC);
                checkValue("aluA", aluA, ctrlPkg::ALU1_FROM_PC);
                checkValue("aluB", aluB, ctrlPkg::ALU2_FROM_1);
            end
            ctrlPkg::RIMMED, ctrlPkg::RADDRESS, ctrlPkg::RABSOLUTE2, ctrlPkg::RSTACK2:
                checkValue("saveMem1", saveMem1, 1'b1);
            ctrlPkg::RABSOLUTE1_1, ctrlPkg::WABSOLUTE1_1:
                checkValue("saveMem2", saveMem2, 1'b1);
            ctrlPkg::WABSOLUTE2, ctrlPkg::WSTACK2: begin
                checkValue("we", we, 1'b1);
                checkValue("writeDataSource", writeDataSource, ctrlPkg::WRITE_FROM_RES);
            end
            ctrlPkg::PUSH2, ctrlPkg::POP1: checkValue("enSP", enSP, 1'b1);
            ctrlPkg::POP2: checkValue("sourceF", sourceF, op[11:9] == 3'd0); // POP into flags
            ctrlPkg::ATYPE, ctrlPkg::ITYPE, ctrlPkg::SITYPE:
                checkValue("aluFunc", aluFunc, expectedAluFunc(op));
            default: begin
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        opcode = '0;
        flags = '0;
        stall = 1'b0;
        $readmemh("sim/controller_cases.txt", caseMem);
        repeat (5) @(negedge clk);
        checkValue("state", state, ctrlPkg::START);
        // Only initSPFP, enSP and enFP high in START
        checkValue("start strobes", {initSPFP, enSP, enFP, enPC, re, we, saveOpcode,
                   readStack, saveMem1, saveMem2, saveResult, enA, enB, enC, enF, sourceF},
                   16'b1110_0000_0000_0000);
        rst = 1'b0;
        @(negedge clk);
        verifyStep(ctrlPkg::FETCH, opcode, 1'b0, '0);
        $display("test reset: %s", errors == 0 ? "ok" : "bad");
        if (errors != 0) begin
            failedTests++;
        end
        assert (!$isunknown(caseMem[0])) else begin
            $display("the cases file sim/controller_cases.txt could not be read");
            errors++;
        end
        for (int c = 0; c < NumCases && !$isunknown(caseMem[0]); c++) begin
            base = c * RecWords;
            errBefore = errors;
            opcode = caseMem[base];
            flags = caseMem[base+1][3:0];
            stallLeft = caseMem[base+2];
            len = caseMem[base+3];
            mainIdx = caseMem[base+4];
            rng = nextRand(rng);
            stallAt = (rng >> 16) % (len - 1); // Path step that gets stretched
            idx = 0;
            while (idx < len - 1) begin
                if (idx == stallAt && stallLeft > 0) begin
                    stall = 1'b1;
                    stallLeft--;
                    #1;
                    snapshot = allOuts;
                    @(negedge clk);
                    checkValue("state while stalled", state, caseMem[base+5+idx]);
                    checkValue("outputs while stalled", allOuts, snapshot);
                end else begin
                    stall = 1'b0;
                    @(negedge clk);
                    idx++;
                    verifyStep(caseMem[base+5+idx][5:0], opcode, idx == mainIdx,
                               caseMem[base+15][5:0]);
                end
            end
            stall = 1'b0;
            if (errors != errBefore) begin
                failedTests++;
            end
            $display("test %0d opcode %h flags %h: %s", c + 1, opcode, flags,
                     errors == errBefore ? "ok" : "bad");
        end
        $display("tests run %0d, tests bad %0d, errors %0d", NumCases + 1, failedTests,
                 errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- all.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/decodeIf.sv
logic/instrDecoder.sv
logic/controlSequencer.sv
logic/datapathControl.sv
logic/memoryControl.sv
logic/cpuController.sv
sim/cpuControllerTb.sv

//--- sim/controller_cases.txt
// opcode flags stall pathLen mainIdx, ten state codes from FETCH back to FETCH (00 pads)
// last word: {enA enB enC we saveResult enF} expected in the step at mainIdx
0251 0 2 3 1 01 02 01 00 00 00 00 00 00 00 21
0482 0 0 3 1 01 02 01 00 00 00 00 00 00 00 11
5634 0 0 3 1 01 03 01 00 00 00 00 00 00 00 09
4005 0 0 3 1 01 03 01 00 00 00 00 00 00 00 01
12B2 0 0 3 1 01 05 01 00 00 00 00 00 00 00 09
8010 0 0 3 1 01 04 01 00 00 00 00 00 00 00 00
2A05 2 0 3 1 01 06 01 00 00 00 00 00 00 00 00
2A05 0 1 2 1 01 01 00 00 00 00 00 00 00 00 00
2003 E 0 3 1 01 06 01 00 00 00 00 00 00 00 00
0801 0 0 4 2 01 14 02 01 00 00 00 00 00 00 21
0C02 0 0 4 2 01 15 02 01 00 00 00 00 00 00 11
0A03 0 3 6 4 01 16 17 18 02 01 00 00 00 00 09
0E01 0 0 5 3 01 19 1A 02 01 00 00 00 00 00 21
7900 0 0 3 1 01 03 01 00 00 00 00 00 00 00 05
4A00 0 2 9 4 01 16 17 18 03 1B 1C 1F 01 00 03
0205 0 0 6 1 01 02 1B 1C 1F 01 00 00 00 00 03
0406 0 0 5 1 01 02 1D 1E 01 00 00 00 00 00 03
1E61 0 0 7 3 01 19 1A 05 1D 1E 01 00 00 00 03
3200 0 0 4 1 01 08 09 01 00 00 00 00 00 00 04
3800 0 0 5 2 01 14 08 09 01 00 00 00 00 00 04
3480 0 1 4 2 01 0A 0B 01 00 00 00 00 00 00 10
3080 0 0 4 2 01 0A 0B 01 00 00 00 00 00 00 01
3C80 0 0 6 2 01 0A 0B 1D 1E 01 00 00 00 00 02
3100 0 1 4 1 01 3F 3F 3F 00 00 00 00 00 00 00
